// ==== list.f ====
+incdir+tests
verilog/rs_pkg.sv
verilog/prio_pick.sv
verilog/wakeup_match.sv
verilog/rs_bank.sv
verilog/dispatch_router.sv
verilog/rs_top.sv
tests/tb_rs.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary -j 0 --timescale 1ns/1ps --top-module tb_rs -f list.f

out=$(./obj_dir/Vtb_rs)
echo "$out"
echo "$out" | grep -q "SIMULATION PASSED"

// ==== tests/rs_checks.svh ====
`ifndef rs_checks_svh
`define rs_checks_svh

// model of the three stations in the order add, mul, div
int depth_of [3] = '{4, 2, 2};             // rs_top default depths
string unit_name [3] = '{"add", "mul", "div"};
logic m_busy [3][4];
dispatch_t m_inst [3][4];
cdb_t [num_cdb-1:0] m_cdb_q;               // what the banks registered at the last edge
logic m_accepted;                          // dispatch taken at the coming edge

function automatic logic cdb_hit(input logic [preg_w-1:0] tag);
    for (int p = 0; p < num_cdb; p++)
        if (m_cdb_q[p].valid && m_cdb_q[p].tag == tag)
            return 1'b1;
    return 1'b0;
endfunction

// lowest empty slot, or with want_ready the lowest entry holding both sources
function automatic int lowest(input int s, input logic want_ready);
    for (int i = 0; i < depth_of[s]; i++)
        if (want_ready ? (m_busy[s][i] && m_inst[s][i].ps1_ready && m_inst[s][i].ps2_ready)
                       : !m_busy[s][i])
            return i;
    return -1;
endfunction

function automatic logic exp_dispatch_ready();
    if (int'(dispatch_sel) > 2)
        return 1'b0;                       // reserved select
    return lowest(int'(dispatch_sel), 1'b0) >= 0;
endfunction

task automatic model_reset();
    for (int s = 0; s < 3; s++)
        for (int i = 0; i < 4; i++)
            m_busy[s][i] = 1'b0;
    m_cdb_q = '0;
    m_accepted = 1'b0;
endtask

// one rising edge wakes from the registered CDB, issues, inserts, then takes in the new CDB
task automatic model_step();
    int f;
    int r;
    dispatch_t nd;
    m_accepted = dispatch_valid && exp_dispatch_ready();
    nd = dispatch;
    nd.ps1_ready = dispatch.ps1_ready | cdb_hit(dispatch.ps1);
    nd.ps2_ready = dispatch.ps2_ready | cdb_hit(dispatch.ps2);
    for (int s = 0; s < 3; s++)
    begin
        f = lowest(s, 1'b0);
        r = lowest(s, 1'b1);
        for (int i = 0; i < depth_of[s]; i++)
        begin
            if (m_busy[s][i] && cdb_hit(m_inst[s][i].ps1))
                m_inst[s][i].ps1_ready = 1'b1;
            if (m_busy[s][i] && cdb_hit(m_inst[s][i].ps2))
                m_inst[s][i].ps2_ready = 1'b1;
        end
        if (r >= 0 && !fu_busy[s])
            m_busy[s][r] = 1'b0;           // issued at this edge
        if (m_accepted && int'(dispatch_sel) == s)
        begin
            m_busy[s][f] = 1'b1;
            m_inst[s][f] = nd;
        end
    end
    m_cdb_q = cdb;
endtask

task automatic check_bit(input logic got, input logic exp, input string name);
    checks++;
    if (got !== exp)
    begin
        errors++;
        $display("FAIL t=%0t %s got %b expected %b", $time, name, got, exp);
    end
endtask

task automatic check_issue(input issue_t got, input issue_t exp, input string name);
    checks++;
    if (got !== exp)
    begin
        errors++;
        $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
    end
endtask

task automatic check_outputs();
    int r;
    logic exp_ready;
    dispatch_t e;
    issue_t exp_issue;
    for (int s = 0; s < 3; s++)
    begin
        r = lowest(s, 1'b1);
        exp_ready = (r >= 0) && !fu_busy[s];
        check_bit(fu_ready[s], exp_ready, {unit_name[s], "_fu_ready"});
        check_bit(full[s], lowest(s, 1'b0) < 0, {unit_name[s], "_full"});
        if (exp_ready)
        begin
            e = m_inst[s][r];
            exp_issue = '{e.ps1, e.ps2, e.pd, e.rd, e.rob, e.op};
            check_issue(fu_issue[s], exp_issue, {unit_name[s], "_issue"});
        end
    end
    check_bit(dispatch_ready, exp_dispatch_ready(), "dispatch_ready");
endtask

`endif

// ==== tests/tb_rs.sv ====
`timescale 1ns/1ps

module tb_rs import rs_pkg::*; ();

    localparam int run_cycles = 3000;
    localparam int timeout_cycles = run_cycles + run_cycles / 6;  // 3500
    localparam int disp_w = $bits(dispatch_t);

    logic clk = 1'b0;
    logic rst = 1'b1;
    logic dispatch_valid = 1'b0;
    fu_sel_t dispatch_sel = fu_add;
    dispatch_t dispatch = '0;
    logic dispatch_ready;
    cdb_t [num_cdb-1:0] cdb = '0;
    logic [2:0] fu_busy = '0;              // add, mul, div
    logic [2:0] fu_ready;
    logic [2:0] full;
    issue_t fu_issue [3];

    int errors = 0;
    int checks = 0;
    int cyc = 0;
    int busy_left [3] = '{0, 0, 0};        // cycles left in a long stall

    `include "rs_checks.svh"

    rs_top uut (
        .clk            (clk),
        .rst            (rst),
        .dispatch_valid (dispatch_valid),
        .dispatch_sel   (dispatch_sel),
        .dispatch       (dispatch),
        .dispatch_ready (dispatch_ready),
        .cdb            (cdb),
        .add_fu_busy    (fu_busy[0]),
        .mul_fu_busy    (fu_busy[1]),
        .div_fu_busy    (fu_busy[2]),
        .add_fu_ready   (fu_ready[0]),
        .mul_fu_ready   (fu_ready[1]),
        .div_fu_ready   (fu_ready[2]),
        .add_issue      (fu_issue[0]),
        .mul_issue      (fu_issue[1]),
        .div_issue      (fu_issue[2]),
        .add_full       (full[0]),
        .mul_full       (full[1]),
        .div_full       (full[2])
    );

    always #4 clk = ~clk;

    // new dispatch once the last one is taken, random stalls, CDB aimed at waiting tags
    task automatic drive_stimulus();
        cdb_t [num_cdb-1:0] c;
        logic [preg_w-1:0] waiting [$];
        if (cyc <= 4)
            dispatch_sel <= fu_sel_t'(2'(cyc - 1));  // walk every select with valid low
        else if (!dispatch_valid || m_accepted)
        begin
            dispatch <= disp_w'({$urandom, $urandom});
            dispatch_valid <= ($urandom_range(9, 0) < 7);
            dispatch_sel <= fu_sel_t'(2'($urandom_range(2, 0)));
        end
        for (int s = 0; s < 3; s++)
        begin
            if (busy_left[s] > 0)
                busy_left[s]--;
            else if ($urandom_range(24, 0) == 0)
                busy_left[s] = int'($urandom_range(45, 15));  // long enough to fill the station
            fu_busy[s] <= (busy_left[s] > 0) || ($urandom_range(3, 0) == 0);
            for (int i = 0; i < depth_of[s]; i++)
            begin
                if (m_busy[s][i] && !m_inst[s][i].ps1_ready)
                    waiting.push_back(m_inst[s][i].ps1);
                if (m_busy[s][i] && !m_inst[s][i].ps2_ready)
                    waiting.push_back(m_inst[s][i].ps2);
            end
        end
        for (int p = 0; p < num_cdb; p++)
        begin
            c[p].valid = ($urandom_range(9, 0) < 7);
            c[p].tag = preg_w'($urandom);
            if (waiting.size() > 0 && $urandom_range(9, 0) < 6)
                c[p].tag = waiting[$urandom_range(waiting.size() - 1, 0)];
        end
        cdb <= c;
    endtask

    initial
    begin
        void'($urandom(32'hb225_473c));
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        repeat (run_cycles) @(posedge clk);
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

    always @(posedge clk)
    begin
        if (!rst)
        begin
            if (cyc >= timeout_cycles)
            begin
                $display("timeout, run still going after %0d cycles", cyc);
                $display("SIMULATION FAILED");
                $finish;
            end
            else
            begin
                cyc++;
                drive_stimulus();
            end
        end
    end

    // outputs are settled half a cycle after the drive edge
    always @(negedge clk)
    begin
        if (rst)
            model_reset();
        else
        begin
            check_outputs();
            model_step();
        end
    end

endmodule

// ==== verilog/rs_top.sv ====
`timescale 1ns/1ps

module rs_top import rs_pkg::*; #(
    parameter int add_depth = 4,
    parameter int mul_depth = 2,
    parameter int div_depth = 2
) (
    input  logic               clk,
    input  logic               rst,

    input  logic               dispatch_valid,
    input  fu_sel_t            dispatch_sel,
    input  dispatch_t          dispatch,
    output logic               dispatch_ready,

    input  cdb_t [num_cdb-1:0] cdb,        // every port reaches every station

    input  logic               add_fu_busy,
    input  logic               mul_fu_busy,
    input  logic               div_fu_busy,
    output logic               add_fu_ready,
    output logic               mul_fu_ready,
    output logic               div_fu_ready,
    output issue_t             add_issue,
    output issue_t             mul_issue,
    output issue_t             div_issue,

    output logic               add_full,
    output logic               mul_full,
    output logic               div_full
);

    logic add_free;
    logic mul_free;
    logic div_free;
    logic add_insert;
    logic mul_insert;
    logic div_insert;

    dispatch_router u_router (
        .dispatch_valid (dispatch_valid),
        .dispatch_sel   (dispatch_sel),
        .add_free       (add_free),
        .mul_free       (mul_free),
        .div_free       (div_free),
        .dispatch_ready (dispatch_ready),
        .add_insert     (add_insert),
        .mul_insert     (mul_insert),
        .div_insert     (div_insert)
    );

    rs_bank #(.depth(add_depth)) u_add_rs (
        .clk      (clk),
        .rst      (rst),
        .insert   (add_insert),
        .entry_in (dispatch),
        .cdb      (cdb),
        .fu_busy  (add_fu_busy),
        .free     (add_free),
        .fu_ready (add_fu_ready),
        .fu_issue (add_issue)
    );

    rs_bank #(.depth(mul_depth)) u_mul_rs (
        .clk      (clk),
        .rst      (rst),
        .insert   (mul_insert),
        .entry_in (dispatch),
        .cdb      (cdb),
        .fu_busy  (mul_fu_busy),
        .free     (mul_free),
        .fu_ready (mul_fu_ready),
        .fu_issue (mul_issue)
    );

    rs_bank #(.depth(div_depth)) u_div_rs (
        .clk      (clk),
        .rst      (rst),
        .insert   (div_insert),
        .entry_in (dispatch),
        .cdb      (cdb),
        .fu_busy  (div_fu_busy),
        .free     (div_free),
        .fu_ready (div_fu_ready),
        .fu_issue (div_issue)
    );

    // full means no empty slot left
    assign add_full = ~add_free;
    assign mul_full = ~mul_free;
    assign div_full = ~div_free;

endmodule

// ==== verilog/dispatch_router.sv ====
`timescale 1ns/1ps

module dispatch_router import rs_pkg::*; (
    input  logic    dispatch_valid,
    input  fu_sel_t dispatch_sel,
    input  logic    add_free,
    input  logic    mul_free,
    input  logic    div_free,
    output logic    dispatch_ready,
    output logic    add_insert,
    output logic    mul_insert,
    output logic    div_insert
);

    logic accept;

    // ready reflects only the addressed station
    always_comb
    begin
        case (dispatch_sel)
            fu_add:  dispatch_ready = add_free;
            fu_mul:  dispatch_ready = mul_free;
            fu_div:  dispatch_ready = div_free;
            default: dispatch_ready = 1'b0;  // reserved select
        endcase
    end

    assign accept = dispatch_valid && dispatch_ready;

    assign add_insert = accept && (dispatch_sel == fu_add);
    assign mul_insert = accept && (dispatch_sel == fu_mul);
    assign div_insert = accept && (dispatch_sel == fu_div);

endmodule

// ==== verilog/rs_bank.sv ====
`timescale 1ns/1ps

module rs_bank import rs_pkg::*; #(
    parameter int depth = 4
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               insert,    // accepted dispatch for this station
    input  dispatch_t          entry_in,
    input  cdb_t [num_cdb-1:0] cdb,
    input  logic               fu_busy,
    output logic               free,
    output logic               fu_ready,
    output issue_t             fu_issue
);

    localparam int iw = (depth > 1) ? $clog2(depth) : 1;

    rs_entry_t entries [depth];
    cdb_t [num_cdb-1:0] cdb_q;             // broadcast seen one edge late

    logic [depth-1:0] empty_vec;
    logic [depth-1:0] ready_vec;
    logic [depth-1:0] ps1_hit;
    logic [depth-1:0] ps2_hit;
    logic in_ps1_hit;
    logic in_ps2_hit;

    logic [iw-1:0] free_idx;
    logic [iw-1:0] issue_idx;
    logic issue_found;
    logic issue_go;

    // per-slot wakeup compare and status
    for (genvar g = 0; g < depth; g++)
    begin : g_slot
        wakeup_match u_wake_ps1 (
            .tag   (entries[g].inst.ps1),
            .cdb_q (cdb_q),
            .hit   (ps1_hit[g])
        );

        wakeup_match u_wake_ps2 (
            .tag   (entries[g].inst.ps2),
            .cdb_q (cdb_q),
            .hit   (ps2_hit[g])
        );

        assign empty_vec[g] = ~entries[g].busy;
        assign ready_vec[g] = entries[g].busy && entries[g].inst.ps1_ready
                              && entries[g].inst.ps2_ready;
    end

    // the incoming instruction may be woken on the very edge it lands
    wakeup_match u_wake_in1 (
        .tag   (entry_in.ps1),
        .cdb_q (cdb_q),
        .hit   (in_ps1_hit)
    );

    wakeup_match u_wake_in2 (
        .tag   (entry_in.ps2),
        .cdb_q (cdb_q),
        .hit   (in_ps2_hit)
    );

    prio_pick #(.n(depth)) u_free_pick (
        .req   (empty_vec),
        .found (free),
        .index (free_idx)
    );

    prio_pick #(.n(depth)) u_issue_pick (
        .req   (ready_vec),
        .found (issue_found),
        .index (issue_idx)
    );

    assign issue_go = issue_found && !fu_busy;
    assign fu_ready = issue_go;

    always_comb
    begin
        fu_issue.ps1 = entries[issue_idx].inst.ps1;
        fu_issue.ps2 = entries[issue_idx].inst.ps2;
        fu_issue.pd  = entries[issue_idx].inst.pd;
        fu_issue.rd  = entries[issue_idx].inst.rd;
        fu_issue.rob = entries[issue_idx].inst.rob;
        fu_issue.op  = entries[issue_idx].inst.op;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            cdb_q <= '0;
            for (int i = 0; i < depth; i++)
            begin
                entries[i].busy <= 1'b0;
            end
        end
        else
        begin
            cdb_q <= cdb;
            for (int i = 0; i < depth; i++)
            begin
                if (entries[i].busy && ps1_hit[i])
                begin
                    entries[i].inst.ps1_ready <= 1'b1;
                end
                if (entries[i].busy && ps2_hit[i])
                begin
                    entries[i].inst.ps2_ready <= 1'b1;
                end
                if (issue_go && (issue_idx == iw'(i)))
                begin
                    entries[i].busy <= 1'b0;  // slot free again next cycle
                end
            end
            // insert only targets an empty slot, so it never meets the issue above
            if (insert)
            begin
                entries[free_idx].busy <= 1'b1;
                entries[free_idx].inst <= entry_in;
                entries[free_idx].inst.ps1_ready <= entry_in.ps1_ready | in_ps1_hit;
                entries[free_idx].inst.ps2_ready <= entry_in.ps2_ready | in_ps2_hit;
            end
        end
    end

endmodule

// ==== verilog/wakeup_match.sv ====
`timescale 1ns/1ps

module wakeup_match import rs_pkg::*; (
    input  logic [preg_w-1:0]      tag,
    input  cdb_t [num_cdb-1:0]     cdb_q,  // registered broadcast ports
    output logic                   hit
);

    always_comb
    begin
        hit = 1'b0;
        for (int p = 0; p < num_cdb; p++)
        begin
            // idle ports never wake anything, whatever tag they carry
            if (cdb_q[p].valid && (cdb_q[p].tag == tag))
            begin
                hit = 1'b1;
            end
        end
    end

endmodule

// ==== verilog/prio_pick.sv ====
`timescale 1ns/1ps

// lowest set bit of req wins
module prio_pick #(
    parameter int n = 4,
    localparam int iw = (n > 1) ? $clog2(n) : 1
) (
    input  logic [n-1:0]  req,
    output logic          found,
    output logic [iw-1:0] index
);

    always_comb
    begin
        found = 1'b0;
        index = '0;
        // walk downward so the last hit is the lowest index
        for (int i = n - 1; i >= 0; i--)
        begin
            if (req[i])
            begin
                found = 1'b1;
                index = iw'(i);
            end
        end
    end

endmodule

// ==== verilog/rs_pkg.sv ====
package rs_pkg;

    // tag and index widths
    localparam int preg_w = 6;  // physical register tag
    localparam int areg_w = 5;  // architectural register number
    localparam int rob_w = 6;   // reorder buffer index
    localparam int op_w = 4;    // opcode carried to the unit

    localparam int num_cdb = 3; // result broadcast ports

    // target station of a dispatched instruction
    // 2'd3 is reserved
    typedef enum logic [1:0] {
        fu_add = 2'd0,
        fu_mul = 2'd1,
        fu_div = 2'd2
    } fu_sel_t;

    // renamed instruction as it leaves dispatch
    typedef struct packed {
        logic [preg_w-1:0] ps1;
        logic [preg_w-1:0] ps2;
        logic ps1_ready;        // source already in the register file
        logic ps2_ready;
        logic [preg_w-1:0] pd;
        logic [areg_w-1:0] rd;
        logic [rob_w-1:0] rob;
        logic [op_w-1:0] op;
    } dispatch_t;

    // one station slot
    typedef struct packed {
        logic busy;             // slot holds a waiting instruction
        dispatch_t inst;
    } rs_entry_t;

    // operands and bookkeeping handed to a functional unit
    typedef struct packed {
        logic [preg_w-1:0] ps1;
        logic [preg_w-1:0] ps2;
        logic [preg_w-1:0] pd;
        logic [areg_w-1:0] rd;
        logic [rob_w-1:0] rob;
        logic [op_w-1:0] op;
    } issue_t;

    // one result broadcast port
    typedef struct packed {
        logic valid;
        logic [preg_w-1:0] tag;
    } cdb_t;

endpackage
